//--- flist.f
verilog/scope_pkg.sv
verilog/command_rx.sv
verilog/adc_capture.sv
verilog/channel_sampler.sv
verilog/frame_sender.sv
verilog/uart_tx.sv
verilog/scope_top.sv
tests/scope_chk.sv
tests/scope_tb.sv

//--- Bender.yml
package:
  name: scope

sources:
  - verilog/scope_pkg.sv
  - verilog/command_rx.sv
  - verilog/adc_capture.sv
  - verilog/channel_sampler.sv
  - verilog/frame_sender.sv
  - verilog/uart_tx.sv
  - verilog/scope_top.sv
  - target: test
    files:
      - tests/scope_chk.sv
      - tests/scope_tb.sv

//--- tests/scope_tb.sv
module scope_tb;
    import scope_pkg::*;

    localparam int NUM_CHANNELS = 2;
    localparam int SAMPLE_DEPTH = 8;
    localparam int CLKS_PER_BIT = 8;
    localparam int FRAME_BYTES  = 1 + 2 * NUM_CHANNELS * SAMPLE_DEPTH;
    // One test at worst sends a frame plus a few command bytes, doubled for margin
    localparam int TEST_BUDGET    = (FRAME_BYTES + 4) * 10 * CLKS_PER_BIT * 2;
    localparam int TIMEOUT_CYCLES = 6 * TEST_BUDGET;

    logic                              sys_clock;
    logic                              i_rst_n;
    logic                              i_rx;
    logic                              i_trigger;
    logic                              i_gate;
    logic                              i_adc_strobe;
    logic [NUM_CHANNELS*ADC_WIDTH-1:0] i_adc_data;
    logic                              o_tx;
    logic                              o_ready;
    logic                              o_busy;

    // Stimulus controls, written by the main sequence and read at the clock edge
    logic strobe_en  = 1'b0;
    logic gate_level = 1'b0;

    // Reference model of the samplers
    sampler_state_t m_state   = S_IDLE;
    byte_t          m_decim   = '0;
    byte_t          m_decim_q = '0;
    int             m_skip    = 0;
    int             m_count   = 0;
    adc_word_t      exp_mem [NUM_CHANNELS][SAMPLE_DEPTH];

    byte_t       rx_q [$];
    int          errors     = 0;
    int          checks     = 0;
    int          test_count = 0;
    int          cycles     = 0;
    logic [31:0] assert_fails [NUM_CHANNELS];

    scope_top #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .SAMPLE_DEPTH (SAMPLE_DEPTH),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut (
        .i_rst_n      (i_rst_n),
        .sys_clock    (sys_clock),
        .i_rx         (i_rx),
        .i_trigger    (i_trigger),
        .i_gate       (i_gate),
        .i_adc_strobe (i_adc_strobe),
        .i_adc_data   (i_adc_data),
        .o_tx         (o_tx),
        .o_ready      (o_ready),
        .o_busy       (o_busy)
    );

    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_assert
        assign assert_fails[c] = dut.g_chan[c].u_sampler.u_chk.fail_count;
    end

    always #2 sys_clock = ~sys_clock;

    always @(posedge sys_clock) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic step();
        @(posedge sys_clock);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, errors - err_start);
    endtask

    // Applies the gating and decimation rules to one valid sample
    task automatic model_sample(input logic [NUM_CHANNELS*ADC_WIDTH-1:0] raw,
                                input logic gate);
        logic store;
        store = 1'b0;
        if (m_state == S_ARMED && gate) begin
            store   = 1'b1;
            m_state = S_FILL;
        end else if (m_state == S_FILL) begin
            if (m_skip == int'(m_decim_q)) begin
                store = 1'b1;
            end else begin
                m_skip++;
            end
        end
        if (store) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                // Offset binary to two's complement
                exp_mem[c][m_count] = raw[c*ADC_WIDTH +: ADC_WIDTH] ^ (1 << (ADC_WIDTH - 1));
            end
            m_count++;
            m_skip = 0;
            if (m_count == SAMPLE_DEPTH) begin
                m_state = S_FULL;
            end
        end
    endtask

    // Sends one 8N1 byte into i_rx LSB first and leaves the line idle after the stop bit
    task automatic send_byte(input byte_t value);
        i_rx = 1'b0;
        repeat (CLKS_PER_BIT) step();
        for (int i = 0; i < 8; i++) begin
            i_rx = value[i];
            repeat (CLKS_PER_BIT) step();
        end
        i_rx = 1'b1;
        repeat (2 * CLKS_PER_BIT) step();
    endtask

    task automatic wait_ready(input logic level, input string what);
        int waited;
        waited = 0;
        while (o_ready !== level && waited < TEST_BUDGET) begin
            step();
            waited++;
        end
        if (o_ready !== level) begin
            errors++;
            $display("%s: o_ready did not go to %0b within %0d cycles", what, level,
                     TEST_BUDGET);
        end
    endtask

    task automatic arm_capture(input logic use_trigger, input logic gate);
        strobe_en  = 1'b0;
        gate_level = gate;
        // Let samples already in flight drain before the samplers arm
        repeat (4) step();
        if (use_trigger) begin
            i_trigger = 1'b1;
            step();
            i_trigger = 1'b0;
        end else begin
            send_byte(CMD_ARM);
        end
        wait_ready(1'b0, "arm");
        m_state   = S_ARMED;
        m_count   = 0;
        m_skip    = 0;
        m_decim_q = m_decim;
        strobe_en = 1'b1;
    endtask

    task automatic receive_frame();
        byte_t     expected [$];
        adc_word_t w;
        int        waited;
        waited = 0;
        while (rx_q.size() < FRAME_BYTES && waited < TEST_BUDGET) begin
            step();
            waited++;
        end
        if (rx_q.size() < FRAME_BYTES) begin
            errors++;
            $display("Frame incomplete: %0d of %0d bytes received", rx_q.size(), FRAME_BYTES);
            rx_q.delete();
        end else begin
            check_value("model sample count", m_count, SAMPLE_DEPTH);
            expected.push_back(FRAME_SYNC);
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                for (int a = 0; a < SAMPLE_DEPTH; a++) begin
                    w = exp_mem[c][a];
                    expected.push_back(w[7:0]);
                    expected.push_back({w[13], w[13], w[13:8]});
                end
            end
            for (int i = 0; i < FRAME_BYTES; i++) begin
                check_value($sformatf("o_tx byte %0d", i), rx_q.pop_front(), expected[i]);
            end
        end
        wait_ready(1'b1, "frame end");
        check_value("o_busy", o_busy, 1'b0);
        check_value("extra o_tx bytes", rx_q.size(), 0);
    endtask

    // A sample strobed in one cycle meets the gate value driven in the next
    initial begin : stimulus
        logic                              strobe_q;
        logic [NUM_CHANNELS*ADC_WIDTH-1:0] data_q;
        logic                              en_now;
        logic                              gate_now;
        strobe_q     = 1'b0;
        data_q       = '0;
        i_adc_strobe = 1'b0;
        i_adc_data   = '0;
        i_gate       = 1'b0;
        forever begin
            @(posedge sys_clock);
            en_now   = strobe_en;
            gate_now = gate_level;
            #1;
            if (strobe_q) begin
                model_sample(data_q, gate_now);
            end
            strobe_q = en_now && ($urandom_range(2) == 0);
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                data_q[c*ADC_WIDTH +: ADC_WIDTH] = ADC_WIDTH'($urandom);
            end
            i_adc_strobe = strobe_q;
            i_adc_data   = data_q;
            i_gate       = gate_now;
        end
    end

    // Decodes o_tx at mid-bit, sampling on the falling clock edge
    initial begin : monitor
        byte_t value;
        forever begin
            @(negedge sys_clock);
            if (i_rst_n === 1'b1 && o_tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge sys_clock);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge sys_clock);
                    value[i] = o_tx;
                end
                repeat (CLKS_PER_BIT) @(negedge sys_clock);
                if (o_tx !== 1'b1) begin
                    errors++;
                    $display("Framing error on o_tx: stop bit not high");
                end
                rx_q.push_back(value);
            end
        end
    end

    initial begin : main
        byte_t decim_value;
        byte_t junk;
        int    gate_wait;
        int    err_start;
        int    waited;
        int    fails;
        sys_clock = 1'b0;
        i_rst_n   = 1'b0;
        i_rx      = 1'b1;
        i_trigger = 1'b0;
        void'($urandom(32'he6f5));
        repeat (16) step();
        i_rst_n = 1'b1;
        step();

        err_start = errors;
        check_value("o_tx", o_tx, 1'b1);
        check_value("o_ready", o_ready, 1'b1);
        check_value("o_busy", o_busy, 1'b0);
        arm_capture(1'b0, 1'b1);
        receive_frame();
        report_test("capture without decimation", err_start);

        err_start   = errors;
        decim_value = byte_t'(1 + $urandom_range(4));
        send_byte(CMD_DECIM);
        send_byte(decim_value);
        m_decim = decim_value;
        arm_capture(1'b0, 1'b1);
        receive_frame();
        report_test("decimated capture", err_start);

        err_start = errors;
        arm_capture(1'b0, 1'b0);
        gate_wait = 10 + $urandom_range(50);
        repeat (gate_wait) step();
        gate_level = 1'b1;
        receive_frame();
        report_test("late gate", err_start);

        err_start = errors;
        arm_capture(1'b1, 1'b1);
        junk = CMD_RESET;
        while (junk == CMD_RESET || junk == CMD_ARM || junk == CMD_DECIM) begin
            junk = 8'($urandom);
        end
        send_byte(junk);
        receive_frame();
        report_test("trigger arm with unknown command", err_start);

        err_start = errors;
        arm_capture(1'b0, 1'b1);
        waited = 0;
        while (m_count < 2 && waited < TEST_BUDGET) begin
            step();
            waited++;
        end
        strobe_en = 1'b0;
        repeat (3) step();
        send_byte(CMD_RESET);
        m_state = S_IDLE;
        wait_ready(1'b1, "command reset");
        // Fresh samples would complete a record that the reset failed to clear
        strobe_en = 1'b1;
        repeat (40 * CLKS_PER_BIT) step();
        check_value("o_tx bytes after reset", rx_q.size(), 0);
        arm_capture(1'b0, 1'b1);
        receive_frame();
        report_test("reset during fill", err_start);

        err_start = errors;
        send_byte(CMD_DECIM);
        send_byte(8'h00);
        m_decim = 8'h00;
        arm_capture(1'b1, 1'b1);
        receive_frame();
        strobe_en = 1'b0;
        repeat (20 * CLKS_PER_BIT) step();
        check_value("o_ready", o_ready, 1'b1);
        check_value("o_busy", o_busy, 1'b0);
        check_value("o_tx", o_tx, 1'b1);
        check_value("stray o_tx bytes", rx_q.size(), 0);
        report_test("idle after frames", err_start);

        fails = 0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            fails += assert_fails[c];
        end
        if (fails != 0) begin
            errors += fails;
            $display("Bound sampler assertions failed %0d times", fails);
        end
        $display("tests %0d, checks %0d, errors %0d", test_count, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- tests/scope_chk.sv
module scope_chk (
    input logic sys_clock,
    input logic i_rst_n,
    input logic i_cmd_reset,
    input logic i_release,
    input logic o_full,
    input logic o_idle
);

    int fail_count = 0;

    // A record has to be armed and filled first, so idle never leads straight to full
    a_no_full_from_idle: assert property (@(posedge sys_clock) disable iff (!i_rst_n)
        o_idle |=> !o_full)
        else begin
            $error("Sampler went from idle to full without a capture");
            fail_count++;
        end

    // A full record stays put until the sender releases it or a reset clears it
    a_full_holds: assert property (@(posedge sys_clock) disable iff (!i_rst_n)
        (o_full && !i_release && !i_cmd_reset) |=> o_full)
        else begin
            $error("Sampler left S_FULL without release or reset");
            fail_count++;
        end

    a_idle_after_reset: assert property (@(posedge sys_clock)
        $rose(i_rst_n) |-> o_idle)
        else begin
            $error("Sampler not idle after reset");
            fail_count++;
        end

endmodule

bind channel_sampler scope_chk u_chk (
    .sys_clock   (sys_clock),
    .i_rst_n     (i_rst_n),
    .i_cmd_reset (i_cmd_reset),
    .i_release   (i_release),
    .o_full      (o_full),
    .o_idle      (o_idle)
);

//--- verilog/scope_top.sv
module scope_top #(
    parameter int NUM_CHANNELS = 2,
    parameter int SAMPLE_DEPTH = 8,
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                                         i_rst_n,
    input  logic                                         sys_clock,
    input  logic                                         i_rx,
    input  logic                                         i_trigger,
    input  logic                                         i_gate,
    input  logic                                         i_adc_strobe,
    input  logic [NUM_CHANNELS*scope_pkg::ADC_WIDTH-1:0] i_adc_data,
    output logic                                         o_tx,
    output logic                                         o_ready,
    output logic                                         o_busy
);
    import scope_pkg::*;

    logic                              cmd_reset;
    logic                              cmd_arm;
    logic                              arm;
    byte_t                             decim;
    logic                              adc_valid;
    logic [NUM_CHANNELS*ADC_WIDTH-1:0] adc_word;
    logic [NUM_CHANNELS-1:0]           full;
    logic [NUM_CHANNELS-1:0]           idle;
    logic [NUM_CHANNELS*ADC_WIDTH-1:0] rd_data;
    logic [$clog2(SAMPLE_DEPTH)-1:0]   rd_addr;
    logic                              release_pulse;
    logic                              tx_start;
    byte_t                             tx_data;

    // Either the serial command or the external trigger starts a capture
    assign arm     = cmd_arm | i_trigger;
    assign o_ready = &idle;

    command_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_command_rx (
        .i_rst_n     (i_rst_n),
        .sys_clock   (sys_clock),
        .i_rx        (i_rx),
        .o_cmd_reset (cmd_reset),
        .o_cmd_arm   (cmd_arm),
        .o_decim     (decim)
    );

    adc_capture #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_adc_capture (
        .i_rst_n      (i_rst_n),
        .sys_clock    (sys_clock),
        .i_adc_strobe (i_adc_strobe),
        .i_adc_data   (i_adc_data),
        .o_adc_valid  (adc_valid),
        .o_adc_word   (adc_word)
    );

    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
        channel_sampler #(
            .SAMPLE_DEPTH (SAMPLE_DEPTH)
        ) u_sampler (
            .i_rst_n     (i_rst_n),
            .sys_clock   (sys_clock),
            .i_arm       (arm),
            .i_cmd_reset (cmd_reset),
            .i_gate      (i_gate),
            .i_adc_valid (adc_valid),
            .i_adc_word  (adc_word[ch*ADC_WIDTH +: ADC_WIDTH]),
            .i_decim     (decim),
            .i_rd_addr   (rd_addr),
            .i_release   (release_pulse),
            .o_full      (full[ch]),
            .o_idle      (idle[ch]),
            .o_rd_data   (rd_data[ch*ADC_WIDTH +: ADC_WIDTH])
        );
    end

    frame_sender #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .SAMPLE_DEPTH (SAMPLE_DEPTH)
    ) u_frame_sender (
        .i_rst_n     (i_rst_n),
        .sys_clock   (sys_clock),
        .i_cmd_reset (cmd_reset),
        .i_full      (full),
        .i_rd_data   (rd_data),
        .i_tx_busy   (o_busy),
        .o_rd_addr   (rd_addr),
        .o_release   (release_pulse),
        .o_tx_start  (tx_start),
        .o_tx_data   (tx_data)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .i_rst_n   (i_rst_n),
        .sys_clock (sys_clock),
        .i_start   (tx_start),
        .i_data    (tx_data),
        .o_tx      (o_tx),
        .o_busy    (o_busy)
    );

endmodule

//--- verilog/uart_tx.sv
module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic             i_rst_n,
    input  logic             sys_clock,
    input  logic             i_start,
    input  scope_pkg::byte_t i_data,
    output logic             o_tx,
    output logic             o_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    // Start bit, eight data bits and stop bit are shifted out from bit 0
    logic [9:0]       shift;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_idx;

    assign o_tx = shift[0];

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            shift   <= '1;
            clk_cnt <= '0;
            bit_idx <= '0;
            o_busy  <= 1'b0;
        end else if (!o_busy) begin
            if (i_start) begin
                shift   <= {1'b1, i_data, 1'b0};
                clk_cnt <= '0;
                bit_idx <= '0;
                o_busy  <= 1'b1;
            end
        end else if (clk_cnt == FULL_BIT) begin
            clk_cnt <= '0;
            // Ones fill in behind, so the line rests high once the stop bit is out
            shift   <= {1'b1, shift[9:1]};
            if (bit_idx == 4'd9) begin
                o_busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

//--- verilog/frame_sender.sv
module frame_sender #(
    parameter int NUM_CHANNELS = 2,
    parameter int SAMPLE_DEPTH = 8
) (
    input  logic                                         i_rst_n,
    input  logic                                         sys_clock,
    input  logic                                         i_cmd_reset,
    input  logic [NUM_CHANNELS-1:0]                      i_full,
    input  logic [NUM_CHANNELS*scope_pkg::ADC_WIDTH-1:0] i_rd_data,
    input  logic                                         i_tx_busy,
    output logic [$clog2(SAMPLE_DEPTH)-1:0]              o_rd_addr,
    output logic                                         o_release,
    output logic                                         o_tx_start,
    output scope_pkg::byte_t                             o_tx_data
);
    import scope_pkg::*;

    localparam int CH_W   = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;
    localparam int ADDR_W = $clog2(SAMPLE_DEPTH);
    localparam logic [CH_W-1:0]   LAST_CH   = CH_W'(NUM_CHANNELS - 1);
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(SAMPLE_DEPTH - 1);

    sender_state_t   state;
    logic [CH_W-1:0] ch;
    adc_word_t       sel_word;
    logic            can_send;

    assign sel_word = i_rd_data[ch*ADC_WIDTH +: ADC_WIDTH];

    // The transmitter raises busy one cycle after start, so a pending start also blocks
    assign can_send = !i_tx_busy && !o_tx_start;

    // Release waits until the last byte has left the serial line
    assign o_release = (state == T_RELEASE) && can_send;

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= T_WAIT;
            ch         <= '0;
            o_rd_addr  <= '0;
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            if (i_cmd_reset) begin
                state     <= T_WAIT;
                ch        <= '0;
                o_rd_addr <= '0;
            end else begin
                case (state)
                    T_WAIT: begin
                        if (&i_full) begin
                            state <= T_SYNC;
                        end
                    end
                    T_SYNC, T_LOW: begin
                        if (can_send) begin
                            o_tx_start <= 1'b1;
                            state      <= (state == T_SYNC) ? T_LOW : T_HIGH;
                        end
                    end
                    T_HIGH: begin
                        if (can_send) begin
                            o_tx_start <= 1'b1;
                            state      <= T_LOW;
                            if (o_rd_addr != LAST_ADDR) begin
                                o_rd_addr <= o_rd_addr + 1'b1;
                            end else begin
                                o_rd_addr <= '0;
                                if (ch == LAST_CH) begin
                                    ch    <= '0;
                                    state <= T_RELEASE;
                                end else begin
                                    ch <= ch + 1'b1;
                                end
                            end
                        end
                    end
                    T_RELEASE: begin
                        if (can_send) begin
                            state <= T_WAIT;
                        end
                    end
                    default: state <= T_WAIT;
                endcase
            end
        end
    end

    // High byte carries bits 13:8 sign extended to eight bits
    always_ff @(posedge sys_clock) begin
        if (can_send) begin
            case (state)
                T_SYNC:  o_tx_data <= FRAME_SYNC;
                T_LOW:   o_tx_data <= sel_word[7:0];
                T_HIGH:  o_tx_data <= {{(16 - ADC_WIDTH){sel_word[ADC_WIDTH-1]}},
                                       sel_word[ADC_WIDTH-1:8]};
                default: o_tx_data <= o_tx_data;
            endcase
        end
    end

endmodule

//--- verilog/channel_sampler.sv
module channel_sampler #(
    parameter int SAMPLE_DEPTH = 8
) (
    input  logic                            i_rst_n,
    input  logic                            sys_clock,
    input  logic                            i_arm,
    input  logic                            i_cmd_reset,
    input  logic                            i_gate,
    input  logic                            i_adc_valid,
    input  scope_pkg::adc_word_t            i_adc_word,
    input  scope_pkg::byte_t                i_decim,
    input  logic [$clog2(SAMPLE_DEPTH)-1:0] i_rd_addr,
    input  logic                            i_release,
    output logic                            o_full,
    output logic                            o_idle,
    output scope_pkg::adc_word_t            o_rd_data
);
    import scope_pkg::*;

    localparam int ADDR_W = $clog2(SAMPLE_DEPTH);
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(SAMPLE_DEPTH - 1);

    sampler_state_t    state;
    byte_t             decim_q;
    byte_t             skip_cnt;
    logic [ADDR_W-1:0] wr_ptr;
    logic              store;
    adc_word_t         mem [SAMPLE_DEPTH];

    // First gated sample opens the record, then every (decim+1)-th valid sample
    assign store = i_adc_valid &&
                   ((state == S_ARMED && i_gate) ||
                    (state == S_FILL && skip_cnt == decim_q));

    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= S_IDLE;
            decim_q  <= '0;
            skip_cnt <= '0;
            wr_ptr   <= '0;
        end else if (i_cmd_reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_arm) begin
                        state    <= S_ARMED;
                        decim_q  <= i_decim;
                        skip_cnt <= '0;
                        wr_ptr   <= '0;
                    end
                end
                S_ARMED, S_FILL: begin
                    if (store) begin
                        skip_cnt <= '0;
                        wr_ptr   <= wr_ptr + 1'b1;
                        state    <= (wr_ptr == LAST_ADDR) ? S_FULL : S_FILL;
                    end else if (state == S_FILL && i_adc_valid) begin
                        skip_cnt <= skip_cnt + 1'b1;
                    end
                end
                default: begin
                    // Samples arriving now are dropped until the sender frees the record
                    if (i_release) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sys_clock) begin
        if (store) begin
            mem[wr_ptr] <= i_adc_word;
        end
        o_rd_data <= mem[i_rd_addr];
    end

    assign o_full = (state == S_FULL);
    assign o_idle = (state == S_IDLE);

endmodule

//--- verilog/adc_capture.sv
module adc_capture #(
    parameter int NUM_CHANNELS = 2
) (
    input  logic                                         i_rst_n,
    input  logic                                         sys_clock,
    input  logic                                         i_adc_strobe,
    input  logic [NUM_CHANNELS*scope_pkg::ADC_WIDTH-1:0] i_adc_data,
    output logic                                         o_adc_valid,
    output logic [NUM_CHANNELS*scope_pkg::ADC_WIDTH-1:0] o_adc_word
);
    import scope_pkg::*;

    // The strobe is delayed by the same register stage as the data
    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_adc_valid <= 1'b0;
        end else begin
            o_adc_valid <= i_adc_strobe;
        end
    end

    // Offset binary becomes two's complement by flipping the MSB of each slice
    always_ff @(posedge sys_clock) begin
        if (i_adc_strobe) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                o_adc_word[ch*ADC_WIDTH +: ADC_WIDTH] <= {
                    ~i_adc_data[ch*ADC_WIDTH + ADC_WIDTH - 1],
                    i_adc_data[ch*ADC_WIDTH +: ADC_WIDTH - 1]
                };
            end
        end
    end

endmodule

//--- verilog/command_rx.sv
module command_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic             i_rst_n,
    input  logic             sys_clock,
    input  logic             i_rx,
    output logic             o_cmd_reset,
    output logic             o_cmd_arm,
    output scope_pkg::byte_t o_decim
);
    import scope_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        R_IDLE,
        R_START,
        R_DATA,
        R_STOP
    } rx_state_t;

    logic [1:0]       rx_sync;
    rx_state_t        rx_state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    byte_t            rx_shift;
    logic             byte_done;
    logic             wait_param;

    // The line idles high, so the synchronizer comes out of reset at ones
    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
        end
    end

    // After the start edge the counter lands on the middle of every bit
    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_state <= R_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
        end else begin
            case (rx_state)
                R_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync[1]) begin
                        rx_state <= R_START;
                    end
                end
                R_START: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt  <= '0;
                        // A glitch that is gone by mid-bit is not a start bit
                        rx_state <= rx_sync[1] ? R_IDLE : R_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                R_DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            rx_state <= R_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt  <= '0;
                        rx_state <= R_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Data arrive LSB first
    always_ff @(posedge sys_clock) begin
        if (rx_state == R_DATA && clk_cnt == FULL_BIT) begin
            rx_shift <= {rx_sync[1], rx_shift[7:1]};
        end
    end

    // A byte counts only when its stop bit reads high
    assign byte_done = (rx_state == R_STOP) && (clk_cnt == FULL_BIT) && rx_sync[1];

    // Decoder either reads an opcode or, after CMD_DECIM, takes the raw parameter byte
    always_ff @(posedge sys_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cmd_reset <= 1'b0;
            o_cmd_arm   <= 1'b0;
            o_decim     <= '0;
            wait_param  <= 1'b0;
        end else begin
            o_cmd_reset <= 1'b0;
            o_cmd_arm   <= 1'b0;
            if (byte_done) begin
                if (wait_param) begin
                    o_decim    <= rx_shift;
                    wait_param <= 1'b0;
                end else begin
                    case (rx_shift)
                        CMD_RESET: o_cmd_reset <= 1'b1;
                        CMD_ARM:   o_cmd_arm   <= 1'b1;
                        CMD_DECIM: wait_param  <= 1'b1;
                        default:   ;
                    endcase
                end
            end
        end
    end

endmodule

//--- verilog/scope_pkg.sv
package scope_pkg;

    // Width of one ADC word and of one converted sample
    localparam int ADC_WIDTH = 14;

    typedef logic [ADC_WIDTH-1:0] adc_word_t;
    typedef logic [7:0]           byte_t;

    // Opcodes accepted on the serial command input
    localparam byte_t CMD_RESET = 8'h52;
    localparam byte_t CMD_ARM   = 8'h53;
    localparam byte_t CMD_DECIM = 8'h44;

    // First byte of every record frame
    localparam byte_t FRAME_SYNC = 8'hA5;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ARMED,
        S_FILL,
        S_FULL
    } sampler_state_t;

    typedef enum logic [2:0] {
        T_WAIT,
        T_SYNC,
        T_LOW,
        T_HIGH,
        T_RELEASE
    } sender_state_t;

endpackage
